//--- Makefile
# Verilator flow for the SHA-256 hashing block

VERILATOR ?= verilator
TOP       ?= tb_hm_top_level
RTL_TOP   ?= hm_top_level
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= ALL TESTS PASSED
VFLAGS    ?= --timing

RTL_SRCS ?= hm_pkg.sv hm_control.sv hm_schedule.sv hm_rounds.sv hm_compare.sv hm_top_level.sv

.PHONY: all lint lint_rtl build sim clean

all: sim

# Lint the RTL alone, then the whole testbench
lint: lint_rtl
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

lint_rtl:
	$(VERILATOR) --lint-only $(RTL_SRCS) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The log decides the result, not the exit status of the model
sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed, see $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- flist.f
hm_pkg.sv
hm_control.sv
hm_schedule.sv
hm_rounds.sv
hm_compare.sv
hm_top_level.sv
tb_hm_checker.sv
tb_hm_top_level.sv

//--- hm_compare.sv
module hm_compare
	import hm_pkg::*;
(
	input  logic    tb_clk,
	input  logic    rst,
	input  digest_t digest,
	input  logic    finish_in,
	input  digest_t difficulty,
	output digest_t valid_hash,
	output logic    valid_hash_flag,
	output logic    hash_done
);

	always_ff @(posedge tb_clk)
	begin
		if (rst)
		begin
			valid_hash      <= '0;
			valid_hash_flag <= 1'b0;
			hash_done       <= 1'b0;
		end
		else
		begin
			hash_done <= finish_in;
			if (finish_in)
			begin
				valid_hash <= digest;
				// Strictly below, as one unsigned 256-bit number
				valid_hash_flag <= (digest < difficulty);
			end
		end
	end

endmodule

//--- hm_control.sv
module hm_control
	import hm_pkg::*;
(
	input  logic        tb_clk,
	input  logic        rst,
	input  logic        begin_hash,
	input  logic        two_chunks,
	input  logic        quit_hash,
	output logic [1:0]  hash_select,
	output ctrl_t       ctrl
);

	typedef enum logic [1:0] {
		s_idle,
		s_load,
		s_rounds,
		s_add
	} state_t;

	state_t     state;
	logic [5:0] round_cnt;
	logic       second_chunk;
	logic       two_q;

	always_ff @(posedge tb_clk)
	begin
		if (rst)
		begin
			state        <= s_idle;
			round_cnt    <= '0;
			second_chunk <= 1'b0;
			two_q        <= 1'b0;
		end
		else if (quit_hash)
		begin
			// Abort drops everything, no completion follows
			state        <= s_idle;
			round_cnt    <= '0;
			second_chunk <= 1'b0;
		end
		else
		begin
			case (state)
				s_idle:
				begin
					if (begin_hash)
					begin
						state        <= s_load;
						two_q        <= two_chunks;
						second_chunk <= 1'b0;
					end
				end
				s_load:
				begin
					state     <= s_rounds;
					round_cnt <= '0;
				end
				s_rounds:
				begin
					round_cnt <= round_cnt + 6'd1;
					if (round_cnt == 6'(ROUNDS - 1))
						state <= s_add;
				end
				s_add:
				begin
					if (two_q && !second_chunk)
					begin
						state        <= s_load;
						second_chunk <= 1'b1;
					end
					else
					begin
						state        <= s_idle;
						second_chunk <= 1'b0;
					end
				end
				default:
					state <= s_idle;
			endcase
		end
	end

	// Chunk fetch index follows the chunk counter
	assign hash_select = {1'b0, second_chunk};

	always_comb
	begin
		ctrl.load        = (state == s_load);
		ctrl.round_en    = (state == s_rounds);
		ctrl.add_en      = (state == s_add);
		ctrl.first_chunk = !second_chunk;
		// Last add of the hash, suppressed when a quit lands on it
		ctrl.finish      = (state == s_add) && (!two_q || second_chunk) && !quit_hash;
		ctrl.round_idx   = round_cnt;
	end

endmodule

//--- hm_pkg.sv
package hm_pkg;

	localparam int ROUNDS = 64;

	// One 512-bit chunk, word 0 in the least significant position
	typedef logic [15:0][31:0] block_t;

	// Digest or difficulty, H0 in word 0, compared as one 256-bit number
	typedef logic [7:0][31:0] digest_t;

	// Working variables of the compression function
	typedef struct packed {
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		logic [31:0] e;
		logic [31:0] f;
		logic [31:0] g;
		logic [31:0] h;
	} work_t;

	// Control strobes from the FSM to the datapath
	typedef struct packed {
		logic       load;
		logic       round_en;
		logic       add_en;
		logic       first_chunk;
		logic       finish;
		logic [5:0] round_idx;
	} ctrl_t;

	localparam logic [0:63][31:0] round_k = {
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// H7 first in the concatenation so H0 lands in word 0
	localparam digest_t hash_iv = {
		32'h5be0cd19, 32'h1f83d9ab, 32'h9b05688c, 32'h510e527f,
		32'ha54ff53a, 32'h3c6ef372, 32'hbb67ae85, 32'h6a09e667
	};

	function automatic logic [31:0] rotr(input logic [31:0] x, input int unsigned n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic logic [31:0] big_sigma0(input logic [31:0] x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic logic [31:0] big_sigma1(input logic [31:0] x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	function automatic logic [31:0] small_sigma0(input logic [31:0] x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic logic [31:0] small_sigma1(input logic [31:0] x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	function automatic logic [31:0] choose(input logic [31:0] e, input logic [31:0] f,
		input logic [31:0] g);
		return (e & f) ^ (~e & g);
	endfunction

	function automatic logic [31:0] majority(input logic [31:0] a, input logic [31:0] b,
		input logic [31:0] c);
		return (a & b) ^ (a & c) ^ (b & c);
	endfunction

endpackage

//--- hm_rounds.sv
module hm_rounds
	import hm_pkg::*;
(
	input  logic        tb_clk,
	input  logic        rst,
	input  ctrl_t       ctrl,
	input  logic [31:0] w_t,
	output digest_t     digest,
	output logic        finish_out
);

	work_t       work;
	digest_t     digest_q;
	digest_t     chain;
	logic        finish_q;
	logic [31:0] t1;
	logic [31:0] t2;
	work_t       work_next;

	// First chunk chains on the initial value, the second on the held digest
	assign chain = ctrl.first_chunk ? hash_iv : digest_q;

	// One compression step
	always_comb
	begin
		t1 = work.h
			+ big_sigma1(work.e)
			+ choose(work.e, work.f, work.g)
			+ round_k[ctrl.round_idx]
			+ w_t;
		t2 = big_sigma0(work.a) + majority(work.a, work.b, work.c);

		work_next.a = t1 + t2;
		work_next.b = work.a;
		work_next.c = work.b;
		work_next.d = work.c;
		work_next.e = work.d + t1;
		work_next.f = work.e;
		work_next.g = work.f;
		work_next.h = work.g;
	end

	always_ff @(posedge tb_clk)
	begin
		if (ctrl.load)
		begin
			work.a <= chain[0];
			work.b <= chain[1];
			work.c <= chain[2];
			work.d <= chain[3];
			work.e <= chain[4];
			work.f <= chain[5];
			work.g <= chain[6];
			work.h <= chain[7];
		end
		else if (ctrl.round_en)
		begin
			work <= work_next;
		end
	end

	// Word-wise add into the chaining value
	always_ff @(posedge tb_clk)
	begin
		if (ctrl.add_en)
		begin
			digest_q[0] <= chain[0] + work.a;
			digest_q[1] <= chain[1] + work.b;
			digest_q[2] <= chain[2] + work.c;
			digest_q[3] <= chain[3] + work.d;
			digest_q[4] <= chain[4] + work.e;
			digest_q[5] <= chain[5] + work.f;
			digest_q[6] <= chain[6] + work.g;
			digest_q[7] <= chain[7] + work.h;
		end
	end

	// Finish lines up with the updated digest
	always_ff @(posedge tb_clk)
	begin
		if (rst)
			finish_q <= 1'b0;
		else
			finish_q <= ctrl.add_en && ctrl.finish;
	end

	assign digest     = digest_q;
	assign finish_out = finish_q;

endmodule

//--- hm_schedule.sv
module hm_schedule
	import hm_pkg::*;
(
	input  logic        tb_clk,
	input  logic        rst,
	input  ctrl_t       ctrl,
	input  block_t      chunk,
	output logic [31:0] w_t
);

	// Window holds W[t] .. W[t+15], W[t] in slot 0
	logic [15:0][31:0] window;
	logic [31:0]       next_word;

	// W[t+16] from the current window
	always_comb
	begin
		next_word = small_sigma1(window[14])
			+ window[9]
			+ small_sigma0(window[1])
			+ window[0];
	end

	always_ff @(posedge tb_clk)
	begin
		if (rst)
		begin
			window <= '0;
		end
		else if (ctrl.load)
		begin
			window <= chunk;
		end
		else if (ctrl.round_en)
		begin
			for (int i = 0; i < 15; i++)
			begin
				window[i] <= window[i + 1];
			end
			window[15] <= next_word;
		end
	end

	// Rounds 0 to 15 see the chunk words unchanged
	assign w_t = window[0];

endmodule

//--- hm_top_level.sv
module hm_top_level
	import hm_pkg::*;
(
	input  logic       tb_clk,
	input  logic       rst,
	input  logic       begin_hash,
	input  logic       two_chunks,
	input  logic       quit_hash,
	input  digest_t    difficulty,
	input  block_t     data_to_hash,
	output logic [1:0] hash_select,
	output logic       hash_done,
	output logic       valid_hash_flag,
	output digest_t    valid_hash
);

	ctrl_t       ctrl;
	logic [31:0] w_t;
	digest_t     digest;
	logic        finish;

	hm_control hm_control_inst (
		.tb_clk      (tb_clk),
		.rst         (rst),
		.begin_hash  (begin_hash),
		.two_chunks  (two_chunks),
		.quit_hash   (quit_hash),
		.hash_select (hash_select),
		.ctrl        (ctrl)
	);

	hm_schedule hm_schedule_inst (
		.tb_clk (tb_clk),
		.rst    (rst),
		.ctrl   (ctrl),
		.chunk  (data_to_hash),
		.w_t    (w_t)
	);

	hm_rounds hm_rounds_inst (
		.tb_clk     (tb_clk),
		.rst        (rst),
		.ctrl       (ctrl),
		.w_t        (w_t),
		.digest     (digest),
		.finish_out (finish)
	);

	hm_compare hm_compare_inst (
		.tb_clk          (tb_clk),
		.rst             (rst),
		.digest          (digest),
		.finish_in       (finish),
		.difficulty      (difficulty),
		.valid_hash      (valid_hash),
		.valid_hash_flag (valid_hash_flag),
		.hash_done       (hash_done)
	);

endmodule

//--- tb_hm_checker.sv
module tb_hm_checker
	import hm_pkg::*;
(
	input  logic       tb_clk,
	input  logic       rst,
	input  logic       hash_done,
	input  logic       valid_hash_flag,
	input  digest_t    valid_hash,
	input  logic [1:0] hash_select,
	input  int         row_idx,
	input  logic       row_two,
	input  logic       expect_done,
	input  digest_t    exp_digest,
	input  logic       exp_flag,
	output int         error_count,
	output int         done_count
);

	int      errors = 0;
	int      dones = 0;
	int      done_row = -1;
	int      seen_row = -1;
	logic    saw_second = 1'b0;
	// Last completed result, which the outputs must hold
	digest_t held_digest = '0;
	logic    held_flag = 1'b0;

	assign error_count = errors;
	assign done_count  = dones;

	task automatic report_value(input string name, input logic [255:0] expected,
		input logic [255:0] actual);
		$display("error at time %0t: %s expected %0h actual %0h", $time, name, expected, actual);
		errors++;
	endtask

	task automatic report_text(input string what);
		$display("failure at time %0t: %s", $time, what);
		errors++;
	endtask

	// Outputs are sampled mid-cycle, away from the rising edge
	always @(negedge tb_clk)
	begin
		if (rst)
		begin
			if (hash_done !== 1'b0)
				report_value("hash_done", 256'd0, {255'd0, hash_done});
			if (valid_hash_flag !== 1'b0)
				report_value("valid_hash_flag", 256'd0, {255'd0, valid_hash_flag});
			if (hash_select !== 2'd0)
				report_value("hash_select", 256'd0, {254'd0, hash_select});
			if (valid_hash !== '0)
				report_value("valid_hash", 256'd0, valid_hash);
		end
		else
		begin
			if (row_idx != seen_row)
			begin
				seen_row   = row_idx;
				saw_second = 1'b0;
			end
			if (hash_select == 2'd1)
				saw_second = 1'b1;
			if (hash_select > 2'd1)
				report_text("hash_select shows a chunk number above 1");
			else if (!row_two && hash_select !== 2'd0)
				report_value("hash_select", 256'd0, {254'd0, hash_select});

			if (hash_done)
			begin
				if (!expect_done)
				begin
					report_text($sformatf("hash_done pulsed when none was due, row %0d", row_idx));
					held_digest = valid_hash;
					held_flag   = valid_hash_flag;
				end
				else if (row_idx == done_row)
				begin
					report_text($sformatf("more than one hash_done for row %0d", row_idx));
					held_digest = valid_hash;
					held_flag   = valid_hash_flag;
				end
				else
				begin
					if (valid_hash !== exp_digest)
						report_value("valid_hash", exp_digest, valid_hash);
					if (valid_hash_flag !== exp_flag)
						report_value("valid_hash_flag", {255'd0, exp_flag}, {255'd0, valid_hash_flag});
					if (row_two && !saw_second)
						report_text("hash_select never reached 1 during a two-chunk hash");
					dones++;
					done_row    = row_idx;
					held_digest = exp_digest;
					held_flag   = exp_flag;
				end
			end
			else
			begin
				// Between completions the result must not move
				if (valid_hash !== held_digest)
				begin
					report_value("valid_hash", held_digest, valid_hash);
					held_digest = valid_hash;
				end
				if (valid_hash_flag !== held_flag)
				begin
					report_value("valid_hash_flag", {255'd0, held_flag}, {255'd0, valid_hash_flag});
					held_flag = valid_hash_flag;
				end
			end
		end
	end

endmodule

//--- tb_hm_top_level.sv
module tb_hm_top_level
	import hm_pkg::*;
();

	localparam int NUM_ROWS       = 8;
	localparam int IDLE_CYCLES    = 140;
	localparam int STRAY_FIRST    = 3;
	localparam int STRAY_LAST     = 60;
	localparam int TIMEOUT_CYCLES = NUM_ROWS * 150 + 50;

	// Pre-padded messages, first word in the most significant position
	localparam logic [511:0] MSG_ABC   = {32'h61626380, {14{32'h00000000}}, 32'h00000018};
	localparam logic [511:0] MSG_EMPTY = {32'h80000000, {15{32'h00000000}}};
	localparam logic [511:0] MSG_TWO_0 = {
		32'h61626364, 32'h62636465, 32'h63646566, 32'h64656667,
		32'h65666768, 32'h66676869, 32'h6768696a, 32'h68696a6b,
		32'h696a6b6c, 32'h6a6b6c6d, 32'h6b6c6d6e, 32'h6c6d6e6f,
		32'h6d6e6f70, 32'h6e6f7071, 32'h80000000, 32'h00000000
	};
	localparam logic [511:0] MSG_TWO_1 = {{15{32'h00000000}}, 32'h000001c0};

	// Reference digests in the usual printed order
	localparam logic [255:0] DIG_ABC =
		256'hba7816bf_8f01cfea_414140de_5dae2223_b00361a3_96177a9c_b410ff61_f20015ad;
	localparam logic [255:0] DIG_EMPTY =
		256'he3b0c442_98fc1c14_9afbf4c8_996fb924_27ae41e4_649b934c_a495991b_7852b855;
	localparam logic [255:0] DIG_TWO =
		256'h248d6a61_d20638b8_e5c02693_0c3e6039_a33ce459_64ff2167_f6ecedd4_19db06c1;

	typedef struct packed {
		logic       two;
		block_t     chunk0;
		block_t     chunk1;
		digest_t    difficulty;
		digest_t    expected;
		logic       flag;
		logic [7:0] quit_at;
	} row_t;

	logic       tb_clk;
	logic       rst;
	logic       begin_hash;
	logic       two_chunks;
	logic       quit_hash;
	digest_t    difficulty;
	block_t     data_to_hash;
	logic [1:0] hash_select;
	logic       hash_done;
	logic       valid_hash_flag;
	digest_t    valid_hash;

	block_t  cur_chunk0;
	block_t  cur_chunk1;
	int      row_idx;
	logic    row_two;
	logic    expect_done;
	digest_t exp_digest;
	logic    exp_flag;
	int      error_count;
	int      done_count;
	int      tb_errors = 0;
	int      expected_dones = 0;
	int      cycle_count = 0;
	int      seed;
	row_t    rows [NUM_ROWS];

	initial
	begin
		tb_clk = 1'b0;
	end

	always #4 tb_clk = ~tb_clk;

	// Environment answers whichever chunk the DUT selects
	assign data_to_hash = (hash_select == 2'd1) ? cur_chunk1 : cur_chunk0;

	hm_top_level hm_top_level_inst (
		.tb_clk          (tb_clk),
		.rst             (rst),
		.begin_hash      (begin_hash),
		.two_chunks      (two_chunks),
		.quit_hash       (quit_hash),
		.difficulty      (difficulty),
		.data_to_hash    (data_to_hash),
		.hash_select     (hash_select),
		.hash_done       (hash_done),
		.valid_hash_flag (valid_hash_flag),
		.valid_hash      (valid_hash)
	);

	tb_hm_checker tb_hm_checker_inst (
		.tb_clk          (tb_clk),
		.rst             (rst),
		.hash_done       (hash_done),
		.valid_hash_flag (valid_hash_flag),
		.valid_hash      (valid_hash),
		.hash_select     (hash_select),
		.row_idx         (row_idx),
		.row_two         (row_two),
		.expect_done     (expect_done),
		.exp_digest      (exp_digest),
		.exp_flag        (exp_flag),
		.error_count     (error_count),
		.done_count      (done_count)
	);

	// Word 0 of the block is the first message word
	function automatic block_t msg_block(input logic [511:0] m);
		block_t b;
		for (int i = 0; i < 16; i++)
		begin
			b[i] = m[511 - 32 * i -: 32];
		end
		return b;
	endfunction

	// Word 0 of the digest is H0
	function automatic digest_t hex_digest(input logic [255:0] d);
		digest_t r;
		for (int i = 0; i < 8; i++)
		begin
			r[i] = d[255 - 32 * i -: 32];
		end
		return r;
	endfunction

	function automatic row_t make_row(input logic two, input logic [511:0] c0,
		input logic [511:0] c1, input digest_t diff, input digest_t expected,
		input logic flag, input int quit_at);
		row_t r;
		r.two        = two;
		r.chunk0     = msg_block(c0);
		r.chunk1     = msg_block(c1);
		r.difficulty = diff;
		r.expected   = expected;
		r.flag       = flag;
		r.quit_at    = 8'(quit_at);
		return r;
	endfunction

	task automatic fill_rows();
		digest_t d_abc;
		digest_t d_empty;
		digest_t d_two;
		digest_t ones;
		d_abc   = hex_digest(DIG_ABC);
		d_empty = hex_digest(DIG_EMPTY);
		d_two   = hex_digest(DIG_TWO);
		ones    = '1;
		rows[0] = make_row(1'b0, MSG_ABC, '0, ones, d_abc, 1'b1, 0);
		rows[1] = make_row(1'b0, MSG_EMPTY, '0, '0, d_empty, 1'b0, 0);
		rows[2] = make_row(1'b1, MSG_TWO_0, MSG_TWO_1, d_two, d_two, 1'b0, 0);
		rows[3] = make_row(1'b0, MSG_ABC, '0, d_abc + 256'd1, d_abc, 1'b1, 0);
		// Abort in the second chunk, then the same message again
		rows[4] = make_row(1'b1, MSG_TWO_0, MSG_TWO_1, ones, d_two, 1'b1, 90);
		rows[5] = make_row(1'b1, MSG_TWO_0, MSG_TWO_1, ones, d_two, 1'b1, 0);
		rows[6] = make_row(1'b0, MSG_ABC, '0, ones, d_abc, 1'b1, 20);
		rows[7] = make_row(1'b0, MSG_EMPTY, '0, d_empty, d_empty, 1'b0, 0);
	endtask

	task automatic run_row(input int idx);
		row_t        r;
		int          cyc;
		logic        done_seen;
		logic [31:0] rnd;
		r = rows[idx];
		@(posedge tb_clk);
		two_chunks  <= r.two;
		difficulty  <= r.difficulty;
		cur_chunk0  <= r.chunk0;
		cur_chunk1  <= r.chunk1;
		row_idx     <= idx;
		row_two     <= r.two;
		expect_done <= (r.quit_at == 8'd0);
		exp_digest  <= r.expected;
		exp_flag    <= r.flag;
		begin_hash  <= 1'b1;
		@(posedge tb_clk);
		begin_hash <= 1'b0;
		if (r.quit_at != 8'd0)
		begin
			repeat (r.quit_at) @(posedge tb_clk);
			quit_hash <= 1'b1;
			@(posedge tb_clk);
			quit_hash <= 1'b0;
			repeat (IDLE_CYCLES) @(posedge tb_clk);
		end
		else
		begin
			cyc       = 0;
			done_seen = 1'b0;
			while (!done_seen)
			begin
				@(posedge tb_clk);
				cyc++;
				rnd = $random(seed);
				// Stray requests only while the DUT is surely busy
				begin_hash <= (cyc >= STRAY_FIRST) && (cyc <= STRAY_LAST) && (rnd[2:0] == 3'd0);
				@(negedge tb_clk);
				done_seen = hash_done;
			end
			@(posedge tb_clk);
			begin_hash <= 1'b0;
		end
	endtask

	always @(posedge tb_clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	initial
	begin
		seed        = 98;
		rst         = 1'b1;
		begin_hash  = 1'b0;
		two_chunks  = 1'b0;
		quit_hash   = 1'b0;
		difficulty  = '0;
		cur_chunk0  = '0;
		cur_chunk1  = '0;
		row_idx     = -1;
		row_two     = 1'b0;
		expect_done = 1'b0;
		exp_digest  = '0;
		exp_flag    = 1'b0;
		fill_rows();
		for (int i = 0; i < NUM_ROWS; i++)
		begin
			if (rows[i].quit_at == 8'd0)
				expected_dones++;
		end
		repeat (2) @(posedge tb_clk);
		rst <= 1'b0;
		for (int i = 0; i < NUM_ROWS; i++)
		begin
			run_row(i);
		end
		repeat (4) @(posedge tb_clk);
		if (done_count != expected_dones)
		begin
			$display("failure: expected %0d completed hashes but saw %0d", expected_dones,
				done_count);
			tb_errors++;
		end
		$display("checker errors %0d, testbench errors %0d, completed hashes %0d",
			error_count, tb_errors, done_count);
		if (error_count + tb_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
